//--- hw/store_pkg.sv
package store_pkg;

	localparam int WORD_SIZE = 32;
	localparam int ROB_SIZE = 8;
	localparam int REG_NUM = 16;
	localparam int STORER_NUM = 2;

	localparam int ROB_TAG_W = $clog2(ROB_SIZE);
	localparam int REG_NUM_W = $clog2(REG_NUM);
	localparam int STATION_ID_W = $clog2(STORER_NUM);

	// instruction layout
	localparam int OPCODE_W = 6;
	localparam int OPCODE_MSB = WORD_SIZE - 1;
	localparam int REG_I_MSB = 25; // data register
	localparam int REG_J_MSB = 21; // base register
	localparam int REG_K_MSB = 17; // offset register for SWRR only
	localparam int IMM_MSB = 13;
	localparam int IMM_W = IMM_MSB + 1;

	typedef logic [WORD_SIZE-1:0] word_t;
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [REG_NUM_W-1:0] reg_num_t;
	typedef logic [STATION_ID_W-1:0] station_id_t;

	typedef enum logic [OPCODE_W-1:0] {
		OP_SW   = 6'b101011,
		OP_SWRR = 6'b101100
	} opcode_t;

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		FIRE // request on the outputs for one cycle
	} station_state_t;

	typedef struct packed {
		logic     ready;
		rob_tag_t tag;
		word_t    value;
	} operand_t;

	typedef struct packed {
		logic [ROB_SIZE-1:0] valid;
		word_t [ROB_SIZE-1:0] data;
	} rob_view_t;

	typedef struct packed {
		logic        strobe;
		station_id_t station;
		rob_tag_t    dest;
		word_t       inst;
	} issue_t;

	typedef struct packed {
		logic     strobe;
		reg_num_t reg_num;
		rob_tag_t tag;
	} rename_t;

	typedef struct packed {
		logic     valid;
		word_t    addr;
		word_t    data;
		rob_tag_t dest;
	} store_req_t;

	// an operand still waiting on a tag picks up the rob word once that entry is valid
	function automatic operand_t resolve_operand(operand_t op, rob_view_t rob);
		operand_t res;
		res = op;
		if (!op.ready && rob.valid[op.tag]) begin
			res.ready = 1'b1;
			res.value = rob.data[op.tag];
		end
		return res;
	endfunction

endpackage

//--- hw/operand_capture.sv
`timescale 1ns/10ps

module operand_capture (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 load,
	input  store_pkg::operand_t  load_value,
	input  store_pkg::rob_view_t rob,
	output store_pkg::operand_t  operand,
	output logic                 resolved
);

	logic                ready_q;
	store_pkg::rob_tag_t tag_q;
	store_pkg::word_t    value_q;

	store_pkg::operand_t stored;
	store_pkg::operand_t current;
	store_pkg::operand_t next_op;

	assign stored.ready = ready_q;
	assign stored.tag = tag_q;
	assign stored.value = value_q;

	// stored operand as seen through this cycle's rob
	assign current = store_pkg::resolve_operand(stored, rob);

	// a load that resolves on its own edge is taken as ready
	always_comb begin
		if (load)
			next_op = store_pkg::resolve_operand(load_value, rob);
		else
			next_op = current;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			ready_q <= 1'b1; // nothing pending
		else
			ready_q <= next_op.ready;
	end

	always_ff @(posedge clk) begin
		tag_q <= next_op.tag;
		value_q <= next_op.value;
	end

	assign operand = stored;
	assign resolved = current.ready;

endmodule

//--- hw/reg_status.sv
`timescale 1ns/10ps

module reg_status (
	input  logic                              clk,
	input  logic                              reset,
	input  store_pkg::rename_t                rename,
	input  store_pkg::issue_t                 issue,
	input  store_pkg::rob_view_t              rob,
	output store_pkg::operand_t               src_i,
	output store_pkg::operand_t               src_j,
	output store_pkg::operand_t               src_k,
	output logic [store_pkg::STORER_NUM-1:0]  issue_sel
);

	store_pkg::word_t              value_q [store_pkg::REG_NUM];
	store_pkg::rob_tag_t           tag_q [store_pkg::REG_NUM];
	logic [store_pkg::REG_NUM-1:0] pending_q;

	store_pkg::opcode_t  opcode;
	store_pkg::reg_num_t reg_i;
	store_pkg::reg_num_t reg_j;
	store_pkg::reg_num_t reg_k;
	store_pkg::word_t    imm;

	// register entry with the rob bypass applied
	function automatic store_pkg::operand_t read_reg(store_pkg::reg_num_t r);
		store_pkg::operand_t op;
		op.ready = !pending_q[r];
		op.tag = tag_q[r];
		op.value = value_q[r];
		return store_pkg::resolve_operand(op, rob);
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int r = 0; r < store_pkg::REG_NUM; r++) begin
				value_q[r] <= '0;
				tag_q[r] <= '0;
			end
			pending_q <= '0;
		end else begin
			for (int r = 0; r < store_pkg::REG_NUM; r++) begin
				if (rename.strobe && rename.reg_num == store_pkg::reg_num_t'(r)) begin
					pending_q[r] <= 1'b1; // rename beats a same-edge result
					tag_q[r] <= rename.tag;
				end else if (pending_q[r] && rob.valid[tag_q[r]]) begin
					pending_q[r] <= 1'b0;
					value_q[r] <= rob.data[tag_q[r]];
				end
			end
		end
	end

	// issue decode
	assign opcode = store_pkg::opcode_t'(issue.inst[store_pkg::OPCODE_MSB -: store_pkg::OPCODE_W]);
	assign reg_i = issue.inst[store_pkg::REG_I_MSB -: store_pkg::REG_NUM_W];
	assign reg_j = issue.inst[store_pkg::REG_J_MSB -: store_pkg::REG_NUM_W];
	assign reg_k = issue.inst[store_pkg::REG_K_MSB -: store_pkg::REG_NUM_W];
	assign imm = {{(store_pkg::WORD_SIZE - store_pkg::IMM_W){1'b0}},
		issue.inst[store_pkg::IMM_MSB:0]};

	always_comb begin
		src_i = read_reg(reg_i);
		src_j = read_reg(reg_j);
		if (opcode == store_pkg::OP_SW) begin
			src_k.ready = 1'b1;
			src_k.tag = '0;
			src_k.value = imm;
		end else begin
			src_k = read_reg(reg_k);
		end
	end

	always_comb begin
		for (int s = 0; s < store_pkg::STORER_NUM; s++)
			issue_sel[s] = issue.strobe && issue.station == store_pkg::station_id_t'(s);
	end

	// renames only ever point at entries still in flight
	a_rename_open_entry: assert property (@(posedge clk) disable iff (reset)
		rename.strobe |-> !rob.valid[rename.tag])
		else $error("rename to an rob entry that already holds its result");

	a_issue_opcode: assert property (@(posedge clk) disable iff (reset)
		issue.strobe |-> (opcode == store_pkg::OP_SW || opcode == store_pkg::OP_SWRR))
		else $error("issue with an undefined store opcode");

endmodule

//--- hw/store_station.sv
`timescale 1ns/10ps

module store_station (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   issue_sel,
	input  store_pkg::rob_tag_t    dest,
	input  store_pkg::operand_t    src_i,
	input  store_pkg::operand_t    src_j,
	input  store_pkg::operand_t    src_k,
	input  store_pkg::rob_view_t   rob,
	output logic                   busy,
	output store_pkg::store_req_t  store_req
);

	store_pkg::station_state_t state_q;
	store_pkg::station_state_t state_d;

	store_pkg::rob_tag_t dest_q;
	store_pkg::word_t    addr_q;
	store_pkg::word_t    data_q;

	store_pkg::operand_t data_op;
	store_pkg::operand_t base_op;
	store_pkg::operand_t offset_op;
	store_pkg::operand_t data_now;
	store_pkg::operand_t base_now;
	store_pkg::operand_t offset_now;

	logic data_rdy;
	logic base_rdy;
	logic offset_rdy;
	logic load;
	logic fire;

	assign busy = (state_q == store_pkg::WAIT);
	assign load = issue_sel && !busy;
	assign fire = busy && data_rdy && base_rdy && offset_rdy;

	operand_capture data_cap (
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.load_value (src_i),
		.rob        (rob),
		.operand    (data_op),
		.resolved   (data_rdy)
	);

	operand_capture base_cap (
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.load_value (src_j),
		.rob        (rob),
		.operand    (base_op),
		.resolved   (base_rdy)
	);

	operand_capture offset_cap (
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.load_value (src_k),
		.rob        (rob),
		.operand    (offset_op),
		.resolved   (offset_rdy)
	);

	// values that are just resolving count at the firing edge
	assign data_now = store_pkg::resolve_operand(data_op, rob);
	assign base_now = store_pkg::resolve_operand(base_op, rob);
	assign offset_now = store_pkg::resolve_operand(offset_op, rob);

	always_comb begin
		state_d = state_q;
		case (state_q)
			store_pkg::IDLE: if (load) state_d = store_pkg::WAIT;
			store_pkg::WAIT: if (fire) state_d = store_pkg::FIRE;
			// busy already low here so a new store may come in
			store_pkg::FIRE: state_d = load ? store_pkg::WAIT : store_pkg::IDLE;
			default: state_d = store_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state_q <= store_pkg::IDLE;
		else
			state_q <= state_d;
	end

	always_ff @(posedge clk) begin
		if (load)
			dest_q <= dest;
		if (fire) begin
			addr_q <= base_now.value - offset_now.value;
			data_q <= data_now.value;
		end
	end

	assign store_req.valid = (state_q == store_pkg::FIRE);
	assign store_req.addr = addr_q;
	assign store_req.data = data_q;
	assign store_req.dest = dest_q;

	a_req_single_cycle: assert property (@(posedge clk) disable iff (reset)
		store_req.valid |=> !store_req.valid)
		else $error("store request held for more than one cycle");

	a_free_after_fire: assert property (@(posedge clk) disable iff (reset)
		fire |=> (!busy && store_req.valid))
		else $error("station still busy or silent after firing");

endmodule

//--- hw/store_unit.sv
`timescale 1ns/10ps

module store_unit (
	input  logic                              clk,
	input  logic                              reset,
	input  store_pkg::issue_t                 issue,
	input  store_pkg::rename_t                rename,
	input  store_pkg::rob_view_t              rob,
	output logic [store_pkg::STORER_NUM-1:0]  busy,
	output store_pkg::store_req_t             store_req [store_pkg::STORER_NUM]
);

	// operands fetched at issue and shared by both stations
	store_pkg::operand_t src_i;
	store_pkg::operand_t src_j;
	store_pkg::operand_t src_k;

	logic [store_pkg::STORER_NUM-1:0] issue_sel;

	reg_status status_i (
		.clk       (clk),
		.reset     (reset),
		.rename    (rename),
		.issue     (issue),
		.rob       (rob),
		.src_i     (src_i),
		.src_j     (src_j),
		.src_k     (src_k),
		.issue_sel (issue_sel)
	);

	for (genvar s = 0; s < store_pkg::STORER_NUM; s++) begin : gen_station
		store_station station_i (
			.clk       (clk),
			.reset     (reset),
			.issue_sel (issue_sel[s]), // one-hot from the status table
			.dest      (issue.dest),
			.src_i     (src_i),
			.src_j     (src_j),
			.src_k     (src_k),
			.rob       (rob),
			.busy      (busy[s]),
			.store_req (store_req[s])
		);
	end

endmodule

//--- verif/store_unit_tb.sv
`timescale 1ns/10ps

module store_unit_tb;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_ISSUES = 600;
	localparam int TIMEOUT_CYCLES = NUM_ISSUES * 40 + 200;

	logic clk;
	logic reset;
	store_pkg::issue_t issue;
	store_pkg::rename_t rename;
	store_pkg::rob_view_t rob;
	logic [store_pkg::STORER_NUM-1:0] busy;
	store_pkg::store_req_t store_req [store_pkg::STORER_NUM];

	// reference model
	store_pkg::word_t reg_val [store_pkg::REG_NUM];
	store_pkg::rob_tag_t reg_tag [store_pkg::REG_NUM];
	logic reg_pend [store_pkg::REG_NUM];
	logic exp_busy [store_pkg::STORER_NUM];
	store_pkg::operand_t exp_op [store_pkg::STORER_NUM][3]; // data, base, offset
	store_pkg::rob_tag_t exp_dest [store_pkg::STORER_NUM];
	store_pkg::store_req_t exp_req [store_pkg::STORER_NUM];

	logic [31:0] lcg_state;
	int issued;
	int seen;

	store_unit dut_i (
		.clk       (clk),
		.reset     (reset),
		.issue     (issue),
		.rename    (rename),
		.rob       (rob),
		.busy      (busy),
		.store_req (store_req)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((RESET_CYCLES + TIMEOUT_CYCLES) * CLK_PERIOD);
		abort_run("watchdog expired before all stores were seen");
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_below(int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:16]) % n; // low lcg bits repeat too fast
	endfunction

	function automatic store_pkg::word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi[31:16], lo[31:16]};
	endfunction

	function automatic store_pkg::operand_t apply_rob(store_pkg::operand_t op);
		store_pkg::operand_t res;
		res = op;
		if (!op.ready && rob.valid[op.tag]) begin
			res.ready = 1'b1;
			res.value = rob.data[op.tag];
		end
		return res;
	endfunction

	function automatic store_pkg::operand_t fetch_reg(store_pkg::reg_num_t r);
		store_pkg::operand_t op;
		op.ready = !reg_pend[r];
		op.tag = reg_tag[r];
		op.value = reg_val[r];
		return apply_rob(op);
	endfunction

	// entries some register or station still needs
	function automatic logic [store_pkg::ROB_SIZE-1:0] waited_tags();
		logic [store_pkg::ROB_SIZE-1:0] m;
		m = '0;
		for (int r = 0; r < store_pkg::REG_NUM; r++)
			if (reg_pend[r]) m[reg_tag[r]] = 1'b1;
		for (int s = 0; s < store_pkg::STORER_NUM; s++)
			for (int k = 0; k < 3; k++)
				if (exp_busy[s] && !exp_op[s][k].ready) m[exp_op[s][k].tag] = 1'b1;
		return m;
	endfunction

	function automatic int pick_entry(logic [store_pkg::ROB_SIZE-1:0] cand);
		int start;
		int t;
		start = rand_below(store_pkg::ROB_SIZE);
		for (int i = 0; i < store_pkg::ROB_SIZE; i++) begin
			t = (start + i) % store_pkg::ROB_SIZE;
			if (cand[t]) return t;
		end
		return -1;
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_busy(string name, logic got, logic exp);
		if (got !== exp)
			abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic check_req(string name, store_pkg::store_req_t got, store_pkg::store_req_t exp);
		if (got.valid !== exp.valid || (exp.valid && got !== exp))
			abort_run($sformatf("** Error at %0t: %s is %b/%h/%h/%0d, expected %b/%h/%h/%0d",
				$time, name, got.valid, got.addr, got.data, got.dest,
				exp.valid, exp.addr, exp.data, exp.dest));
	endtask

	task automatic expect_seen(int n);
		if (seen != n)
			abort_run($sformatf("expected %0d store requests by now, saw %0d", n, seen));
	endtask

	// checks the last rising edge at the next falling edge and then drops the strobes
	task automatic begin_cycle();
		@(negedge clk);
		for (int s = 0; s < store_pkg::STORER_NUM; s++) begin
			check_busy($sformatf("busy[%0d]", s), busy[s], exp_busy[s]);
			check_req($sformatf("store_req[%0d]", s), store_req[s], exp_req[s]);
			if (store_req[s].valid === 1'b1) seen++;
		end
		issue.strobe = 1'b0;
		rename.strobe = 1'b0;
	endtask

	// moves the model across the coming rising edge with the inputs now driven
	task automatic advance_model();
		store_pkg::operand_t src [3];
		store_pkg::operand_t cur [3];
		store_pkg::word_t inst;
		logic fire;
		logic load;
		inst = issue.inst;
		src[0] = fetch_reg(inst[25:22]);
		src[1] = fetch_reg(inst[21:18]);
		if (store_pkg::opcode_t'(inst[31:26]) == store_pkg::OP_SW) begin
			src[2].ready = 1'b1;
			src[2].tag = '0;
			src[2].value = {18'b0, inst[13:0]};
		end else
			src[2] = fetch_reg(inst[17:14]);
		for (int s = 0; s < store_pkg::STORER_NUM; s++) begin
			for (int k = 0; k < 3; k++)
				cur[k] = apply_rob(exp_op[s][k]);
			fire = exp_busy[s] && cur[0].ready && cur[1].ready && cur[2].ready;
			load = issue.strobe && issue.station == store_pkg::station_id_t'(s) && !exp_busy[s];
			exp_req[s].valid = fire;
			if (fire) begin
				exp_req[s].addr = cur[1].value - cur[2].value;
				exp_req[s].data = cur[0].value;
				exp_req[s].dest = exp_dest[s];
				exp_busy[s] = 1'b0;
			end
			if (load) begin
				exp_busy[s] = 1'b1;
				exp_dest[s] = issue.dest;
				issued++;
			end
			for (int k = 0; k < 3; k++)
				exp_op[s][k] = load ? apply_rob(src[k]) : cur[k];
		end
		for (int r = 0; r < store_pkg::REG_NUM; r++) begin
			if (rename.strobe && rename.reg_num == store_pkg::reg_num_t'(r)) begin
				reg_pend[r] = 1'b1;
				reg_tag[r] = rename.tag;
			end else if (reg_pend[r] && rob.valid[reg_tag[r]]) begin
				reg_pend[r] = 1'b0;
				reg_val[r] = rob.data[reg_tag[r]];
			end
		end
	endtask

	task automatic idle_cycles(int n);
		repeat (n) begin
			begin_cycle();
			advance_model();
		end
	endtask

	task automatic issue_store(int station, store_pkg::opcode_t op, int ri, int rj, int rk,
		int imm, int dest);
		store_pkg::word_t inst;
		inst = '0;
		inst[31:26] = op;
		inst[25:22] = store_pkg::reg_num_t'(ri);
		inst[21:18] = store_pkg::reg_num_t'(rj);
		inst[17:14] = store_pkg::reg_num_t'(rk);
		inst[13:0] = imm[13:0];
		issue.strobe = 1'b1;
		issue.station = store_pkg::station_id_t'(station);
		issue.dest = store_pkg::rob_tag_t'(dest);
		issue.inst = inst;
	endtask

	task automatic rename_reg(int r, int t);
		rename.strobe = 1'b1;
		rename.reg_num = store_pkg::reg_num_t'(r);
		rename.tag = store_pkg::rob_tag_t'(t);
	endtask

	task automatic set_entry(int t, store_pkg::word_t value);
		rob.valid[t] = 1'b1;
		rob.data[t] = value;
	endtask

	// hands a result to one entry that a register or station still waits on
	task automatic release_waited_entry();
		int t;
		t = pick_entry(waited_tags() & ~rob.valid);
		if (t >= 0) set_entry(t, rand_word());
	endtask

	task automatic drive_random();
		int t;
		int s;
		t = rand_below(4);
		if (t == 0) begin
			t = pick_entry(~rob.valid);
			if (t >= 0) set_entry(t, rand_word());
		end else if (t == 1) begin
			t = pick_entry(rob.valid & ~waited_tags()); // only entries nobody needs
			if (t >= 0) rob.valid[t] = 1'b0;
		end
		if (rand_below(4) == 0) begin
			t = pick_entry(~rob.valid);
			if (t >= 0) rename_reg(rand_below(store_pkg::REG_NUM), t);
		end
		if (rand_below(2) == 0) begin
			s = rand_below(store_pkg::STORER_NUM);
			if (exp_busy[s]) s = 1 - s;
			if (!exp_busy[s]) begin
				issue_store(s, (rand_below(2) == 0) ? store_pkg::OP_SW : store_pkg::OP_SWRR,
					rand_below(16), rand_below(16), rand_below(16), rand_below(16384),
					rand_below(store_pkg::ROB_SIZE));
			end
		end
	endtask

	initial begin
		int first;
		lcg_state = 32'h6990_bbcc;
		issue = '0;
		rename = '0;
		rob = '0;
		issued = 0;
		seen = 0;
		for (int r = 0; r < store_pkg::REG_NUM; r++) begin
			reg_val[r] = '0;
			reg_tag[r] = '0;
			reg_pend[r] = 1'b0;
		end
		for (int s = 0; s < store_pkg::STORER_NUM; s++) begin
			exp_busy[s] = 1'b0;
			exp_dest[s] = '0;
			exp_req[s] = '0;
			for (int k = 0; k < 3; k++)
				exp_op[s][k] = '{ready: 1'b1, tag: '0, value: '0};
		end
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		begin_cycle(); // idle outputs while still in reset
		reset = 1'b0;

		// registers all zero after reset
		begin_cycle();
		issue_store(0, store_pkg::OP_SW, 3, 5, 0, 0, 0);
		advance_model();
		idle_cycles(3);
		expect_seen(1);

		// entry turns valid on the issue cycle itself
		begin_cycle();
		rename_reg(2, 1);
		advance_model();
		begin_cycle();
		set_entry(1, 32'h1234_5678);
		issue_store(0, store_pkg::OP_SW, 2, 2, 0, 'h10, 1);
		advance_model();
		idle_cycles(3);
		expect_seen(2);

		// register offset with data and base pending
		begin_cycle();
		rename_reg(4, 2);
		advance_model();
		begin_cycle();
		rename_reg(6, 3);
		advance_model();
		begin_cycle();
		issue_store(1, store_pkg::OP_SWRR, 4, 6, 2, 0, 5);
		advance_model();
		idle_cycles(2);
		begin_cycle();
		set_entry(2, 32'h0000_0040);
		advance_model();
		begin_cycle();
		set_entry(3, 32'h0001_0000);
		advance_model();
		idle_cycles(3);
		expect_seen(3);

		first = issued;
		while (issued - first < NUM_ISSUES) begin
			begin_cycle();
			drive_random();
			advance_model();
		end
		do begin
			begin_cycle();
			release_waited_entry();
			advance_model();
		end while (exp_busy[0] || exp_busy[1] || exp_req[0].valid || exp_req[1].valid);
		begin_cycle();

		if (seen != issued) begin
			abort_run($sformatf("%0d stores issued but %0d requests seen", issued, seen));
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

//--- project.f
hw/store_pkg.sv
hw/operand_capture.sv
hw/reg_status.sv
hw/store_station.sv
hw/store_unit.sv
verif/store_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f project.f --top-module store_unit_tb; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vstore_unit_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1
